// ==== source/rvv_isa_pkg.sv ====
// RISC-V vector ISA definitions for the vector front end
// Major opcode, LMUL, SEW and fixed-point rounding encodings
// Vset and arithmetic bit views of the instruction body, joined in one union
// Architectural configuration state and its reset values
package rvv_isa_pkg;

  // Width of the vstart CSR as carried in the configuration state
  localparam int VSTART_W = 7;

  // Major opcode of a dispatched vector instruction
  typedef enum logic [1:0] {
    LOAD  = 2'b00,
    STORE = 2'b01,
    RVV   = 2'b10
  } rvv_opcode_e;

  // Register group multiplier, vtype encoding
  typedef enum logic [2:0] {
    LMUL1     = 3'b000,
    LMUL2     = 3'b001,
    LMUL4     = 3'b010,
    LMUL8     = 3'b011,
    LMUL_RSVD = 3'b100,
    LMUL1_8   = 3'b101,
    LMUL1_4   = 3'b110,
    LMUL1_2   = 3'b111
  } rvv_lmul_e;

  // Selected element width, vtype encoding
  typedef enum logic [2:0] {
    SEW8  = 3'b000,
    SEW16 = 3'b001,
    SEW32 = 3'b010
  } rvv_sew_e;

  // Fixed-point rounding mode from vxrm
  typedef enum logic [1:0] {
    RNU = 2'b00,
    RNE = 2'b01,
    RDN = 2'b10,
    ROD = 2'b11
  } rvv_xrm_e;

  // Body seen as vsetvli / vsetivli / vsetvl
  // sel[1] low is vsetvli, 2'b11 is vsetivli, 2'b10 is vsetvl
  typedef struct packed {
    logic [1:0] sel;
    logic [1:0] rsvd;      // upper zimm bits, ignored
    logic       ma;
    logic       ta;
    rvv_sew_e   sew;
    rvv_lmul_e  lmul;
    logic [4:0] rs1_uimm;  // rs1 index, or AVL immediate for vsetivli
    logic [2:0] funct3;
    logic [4:0] rd;
  } rvv_vset_fields_t;

  // Body seen as an OP-V arithmetic instruction
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1_rs1;
    logic [2:0] funct3;
    logic [4:0] vd;
  } rvv_arith_fields_t;

  // Same 25 bits, funct3 sits at [7:5] in both views
  typedef union packed {
    rvv_vset_fields_t  vset;
    rvv_arith_fields_t arith;
  } rvv_bits_u;

  typedef struct packed {
    rvv_opcode_e opcode;
    rvv_bits_u   bits;
  } rvv_inst_t;

  // Configuration in force for one instruction
  typedef struct packed {
    logic [31:0]         vl;
    logic [VSTART_W-1:0] vstart;
    rvv_xrm_e            xrm;
    rvv_lmul_e           lmul;
    rvv_sew_e            sew;
    logic                ta;
    logic                ma;
  } rvv_config_t;

  // Configuration after reset
  localparam logic [31:0] CFG_RESET_VL   = 32'd16;
  localparam rvv_sew_e    CFG_RESET_SEW  = SEW8;
  localparam rvv_lmul_e   CFG_RESET_LMUL = LMUL1;

endpackage

// ==== source/rvv_cmd_pkg.sv ====
// Command and writeback types of the vector front end
// Queued command: instruction, configuration in force and rs1 value
// Scalar register writeback produced by vset instructions
package rvv_cmd_pkg;

  import rvv_isa_pkg::*;

  // One entry of the command queue
  typedef struct packed {
    rvv_opcode_e opcode;
    rvv_bits_u   bits;
    // State that holds at this position in the dispatch group
    rvv_config_t arch_state;
    // Scalar operand, zero for pure vector-vector forms
    logic [31:0] rs1;
  } rvv_cmd_t;

  // Write of the new vl back into rd
  typedef struct packed {
    logic        valid;
    logic [4:0]  addr;
    logic [31:0] data;
  } reg_wb_t;

endpackage

// ==== source/cmd_aligner.sv ====
// Command lane compaction
// Moves valid lanes down to the lowest lanes, keeping program order
`timescale 1ns/100ps

module cmd_aligner
  import rvv_cmd_pkg::*;
#(
  parameter int N = 4
) (
  input  logic [N-1:0]     valid_i,
  input  rvv_cmd_t [N-1:0] cmd_i,
  output logic [N-1:0]     valid_o,
  output rvv_cmd_t [N-1:0] cmd_o
);

  localparam int IDX_BITS = (N > 1) ? $clog2(N) : 1;

  // Output lane k takes the k-th valid input
  always_comb begin
    logic [IDX_BITS-1:0] slot;
    valid_o = '0;
    cmd_o = '0;
    slot = '0;
    for (int i = 0; i < N; i++) begin
      if (valid_i[i]) begin
        valid_o[slot] = 1'b1;
        cmd_o[slot] = cmd_i[i];
        // Wraps only after the last lane, when nothing is left to place
        slot = slot + 1'b1;
      end
    end
  end

endmodule

// ==== source/cmd_queue.sv ====
// Vector command queue
// Circular buffer taking up to N aligned commands per cycle
// Single pop per cycle from the head, free slot count for acceptance
`timescale 1ns/100ps

module cmd_queue
  import rvv_cmd_pkg::*;
#(
  parameter int N           = 4,
  parameter int QUEUE_DEPTH = 16,
  parameter int CAP_BITS    = 5
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic [N-1:0]        push_valid_i,
  input  rvv_cmd_t [N-1:0]    push_cmd_i,
  input  logic                pop_i,
  output logic                head_valid_o,
  output rvv_cmd_t            head_cmd_o,
  output logic [CAP_BITS-1:0] free_slots_o
);

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int SUM_BITS = CAP_BITS + 1;

  rvv_cmd_t            mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [CAP_BITS-1:0] count_q;
  logic [CAP_BITS-1:0] push_count;
  logic                do_pop;

  // Pointer advance modulo depth, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] wrap_add(input logic [PTR_BITS-1:0] ptr,
                                                   input logic [CAP_BITS-1:0] inc);
    logic [SUM_BITS-1:0] sum;
    sum = SUM_BITS'(ptr) + SUM_BITS'(inc);
    if (sum >= SUM_BITS'(QUEUE_DEPTH)) begin
      sum = sum - SUM_BITS'(QUEUE_DEPTH);
    end
    return sum[PTR_BITS-1:0];
  endfunction

  // Push lanes are contiguous from lane 0, a popcount gives the advance
  always_comb begin
    push_count = '0;
    for (int k = 0; k < N; k++) begin
      push_count = push_count + CAP_BITS'(push_valid_i[k]);
    end
  end

  // Pop on empty is ignored
  assign do_pop = pop_i && (count_q != '0);

  assign head_valid_o = (count_q != '0);
  assign head_cmd_o = mem[rd_ptr_q];
  assign free_slots_o = CAP_BITS'(QUEUE_DEPTH) - count_q;

  // Lane k lands k entries past the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < N; k++) begin
      if (push_valid_i[k]) begin
        mem[wrap_add(wr_ptr_q, CAP_BITS'(k))] <= push_cmd_i[k];
      end
    end
  end

  // Push and pop in the same cycle both apply
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
    end else begin
      wr_ptr_q <= wrap_add(wr_ptr_q, push_count);
      rd_ptr_q <= wrap_add(rd_ptr_q, CAP_BITS'(do_pop));
      count_q <= count_q + push_count - CAP_BITS'(do_pop);
    end
  end

endmodule

// ==== source/rvv_front_end.sv ====
// Vector front end
// Lane acceptance against remaining queue capacity
// One cycle staging while scalar operands are read
// vtype/vl update chain across the staged group
// Command assembly and vl writeback for vset instructions
`timescale 1ns/100ps

module rvv_front_end
  import rvv_isa_pkg::*;
  import rvv_cmd_pkg::*;
#(
  parameter int N        = 4,
  parameter int CAP_BITS = 5
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [VSTART_W-1:0]   vstart_i,
  input  rvv_xrm_e              vxrm_i,
  input  logic [N-1:0]          inst_valid_i,
  input  rvv_inst_t [N-1:0]     inst_i,
  output logic [N-1:0]          inst_ready_o,
  input  logic [2*N-1:0][31:0]  reg_data_i,
  input  logic [CAP_BITS-1:0]   free_slots_i,
  output reg_wb_t [N-1:0]       reg_wb_o,
  output logic [N-1:0]          cmd_valid_o,
  output rvv_cmd_t [N-1:0]      cmd_o,
  output logic                  config_valid_o,
  output rvv_config_t           config_o
);

  localparam int COUNT_BITS = $clog2(N + 1);

  // Number of valid input lanes below each lane
  logic [COUNT_BITS-1:0] valid_psum [N];
  logic [CAP_BITS-1:0]   capacity;
  logic [COUNT_BITS-1:0] accept_count;

  // Instructions accepted last cycle, waiting for operands
  logic [N-1:0]          staged_valid_q;
  logic [COUNT_BITS-1:0] staged_count_q;
  rvv_inst_t [N-1:0]     staged_inst_q;

  // Architectural configuration and its per-lane chain
  rvv_config_t cfg_q;
  rvv_config_t cfg_chain [N+1];
  logic [N-1:0] is_vset;

  // Staged commands are not yet in the queue, so hold their slots back
  always_comb begin
    capacity = free_slots_i - CAP_BITS'(staged_count_q);
    valid_psum[0] = '0;
    accept_count = '0;
    for (int i = 0; i < N; i++) begin
      if (i + 1 < N) begin
        valid_psum[i+1] = valid_psum[i] + COUNT_BITS'(inst_valid_i[i]);
      end
      // Lowest valid lanes win, up to the remaining capacity
      inst_ready_o[i] = inst_valid_i[i] && (CAP_BITS'(valid_psum[i]) < capacity);
      accept_count = accept_count + COUNT_BITS'(inst_ready_o[i]);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      staged_valid_q <= '0;
      staged_count_q <= '0;
    end else begin
      staged_valid_q <= inst_ready_o;
      staged_count_q <= accept_count;
    end
  end

  always_ff @(posedge clk) begin
    staged_inst_q <= inst_i;
  end

  // Lane i sees cfg_chain[i], a vset in lane i produces cfg_chain[i+1]
  always_comb begin
    rvv_vset_fields_t vset;
    logic [31:0]      rs1_val;
    logic [31:0]      rs2_val;
    cfg_chain[0] = cfg_q;
    // Live CSR values override the stored copy
    cfg_chain[0].vstart = vstart_i;
    cfg_chain[0].xrm = vxrm_i;
    for (int i = 0; i < N; i++) begin
      vset = staged_inst_q[i].bits.vset;
      rs1_val = reg_data_i[2*i];
      rs2_val = reg_data_i[2*i+1];
      cfg_chain[i+1] = cfg_chain[i];
      // OPCFG space, funct3 all ones
      is_vset[i] = staged_valid_q[i] && (staged_inst_q[i].opcode == RVV) &&
                   (vset.funct3 == 3'b111);
      if (is_vset[i]) begin
        if (!vset.sel[1]) begin
          // vsetvli, AVL from rs1
          cfg_chain[i+1].vl = rs1_val;
          cfg_chain[i+1].lmul = vset.lmul;
          cfg_chain[i+1].sew = vset.sew;
          cfg_chain[i+1].ta = vset.ta;
          cfg_chain[i+1].ma = vset.ma;
        end else if (vset.sel[0]) begin
          // vsetivli, AVL is the 5-bit immediate
          cfg_chain[i+1].vl = 32'(vset.rs1_uimm);
          cfg_chain[i+1].lmul = vset.lmul;
          cfg_chain[i+1].sew = vset.sew;
          cfg_chain[i+1].ta = vset.ta;
          cfg_chain[i+1].ma = vset.ma;
        end else begin
          // vsetvl, vtype taken from rs2
          cfg_chain[i+1].vl = rs1_val;
          cfg_chain[i+1].lmul = rvv_lmul_e'(rs2_val[2:0]);
          cfg_chain[i+1].sew = rvv_sew_e'(rs2_val[5:3]);
          cfg_chain[i+1].ta = rs2_val[6];
          cfg_chain[i+1].ma = rs2_val[7];
        end
      end
    end
  end

  // State after the last lane becomes the new architectural state
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_q <= '{
        vl:     CFG_RESET_VL,
        vstart: '0,
        xrm:    RNU,
        lmul:   CFG_RESET_LMUL,
        sew:    CFG_RESET_SEW,
        ta:     1'b0,
        ma:     1'b0
      };
    end else if (|staged_valid_q) begin
      cfg_q <= cfg_chain[N];
    end
  end

  // Stable only while nothing is in flight through the chain
  assign config_valid_o = ~|staged_valid_q;
  assign config_o = cfg_q;

  // Lanes stay unaligned here
  always_comb begin
    for (int i = 0; i < N; i++) begin
      cmd_valid_o[i] = staged_valid_q[i] && !is_vset[i];
      cmd_o[i].opcode = staged_inst_q[i].opcode;
      cmd_o[i].bits = staged_inst_q[i].bits;
      cmd_o[i].arch_state = cfg_chain[i];
      // funct3[2] marks the .vx/.vf style forms
      cmd_o[i].rs1 = staged_inst_q[i].bits.arith.funct3[2] ? reg_data_i[2*i] : '0;
      // New vl goes back to rd
      reg_wb_o[i].valid = is_vset[i];
      reg_wb_o[i].addr = staged_inst_q[i].bits.vset.rd;
      reg_wb_o[i].data = cfg_chain[i+1].vl;
    end
  end

endmodule

// ==== source/rvv_frontend_top.sv ====
// Top level of the vector front end
// Front end, command aligner and command queue
// Sets lane count and queue depth for all blocks
`timescale 1ns/100ps

module rvv_frontend_top
  import rvv_isa_pkg::*;
  import rvv_cmd_pkg::*;
#(
  parameter int N           = 4,
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [N-1:0]         inst_valid_i,
  input  rvv_inst_t [N-1:0]    inst_i,
  output logic [N-1:0]         inst_ready_o,
  input  logic [2*N-1:0][31:0] reg_data_i,
  input  logic [VSTART_W-1:0]  vstart_i,
  input  rvv_xrm_e             vxrm_i,
  output reg_wb_t [N-1:0]      reg_wb_o,
  input  logic                 cmd_pop_i,
  output logic                 cmd_valid_o,
  output rvv_cmd_t             cmd_o,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0] free_slots_o,
  output logic                 config_valid_o,
  output rvv_config_t          config_o
);

  // Wide enough for a full queue
  localparam int CAP_BITS = $clog2(QUEUE_DEPTH + 1);

  // Front end to aligner, lanes may have holes
  logic [N-1:0]     fe_valid;
  rvv_cmd_t [N-1:0] fe_cmd;
  // Aligner to queue, packed to the low lanes
  logic [N-1:0]     push_valid;
  rvv_cmd_t [N-1:0] push_cmd;

  rvv_front_end #(
    .N        (N),
    .CAP_BITS (CAP_BITS)
  ) u_front_end (
    .clk            (clk),
    .rstn           (rstn),
    .vstart_i       (vstart_i),
    .vxrm_i         (vxrm_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .inst_ready_o   (inst_ready_o),
    .reg_data_i     (reg_data_i),
    .free_slots_i   (free_slots_o),
    .reg_wb_o       (reg_wb_o),
    .cmd_valid_o    (fe_valid),
    .cmd_o          (fe_cmd),
    .config_valid_o (config_valid_o),
    .config_o       (config_o)
  );

  cmd_aligner #(
    .N (N)
  ) u_aligner (
    .valid_i (fe_valid),
    .cmd_i   (fe_cmd),
    .valid_o (push_valid),
    .cmd_o   (push_cmd)
  );

  cmd_queue #(
    .N           (N),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CAP_BITS    (CAP_BITS)
  ) u_queue (
    .clk          (clk),
    .rstn         (rstn),
    .push_valid_i (push_valid),
    .push_cmd_i   (push_cmd),
    .pop_i        (cmd_pop_i),
    .head_valid_o (cmd_valid_o),
    .head_cmd_o   (cmd_o),
    .free_slots_o (free_slots_o)
  );

endmodule

// ==== bench/rvv_frontend_tb.sv ====
// Testbench for the vector front end top level
// Stimulus table built at time zero and applied one row per cycle
// Reference model of the configuration state and the expected command queue
// Galois LFSR for operand values and filler bits, watchdog timer
`timescale 1ns/100ps

module rvv_frontend_tb
  import rvv_isa_pkg::*;
  import rvv_cmd_pkg::*;
();

  localparam int N     = 4;
  localparam int DEPTH = 16;
  localparam int NROWS = 31;

  // One table row, applied during one cycle
  typedef struct packed {
    logic [N-1:0]         valid;
    rvv_inst_t [N-1:0]    inst;
    // Operands of this row, driven in the following cycle
    logic [2*N-1:0][31:0] regs;
    logic                 pop;
    logic [VSTART_W-1:0]  vstart;
    rvv_xrm_e             vxrm;
    logic [N-1:0]         exp_ready;
    // Writebacks expected one cycle after this row
    logic [N-1:0]         exp_wb;
    logic [N-1:0][4:0]    wb_addr;
    logic [N-1:0][31:0]   wb_data;
  } row_t;

  logic                 clk;
  logic                 rstn;
  logic [N-1:0]         inst_valid_i;
  rvv_inst_t [N-1:0]    inst_i;
  logic [N-1:0]         inst_ready_o;
  logic [2*N-1:0][31:0] reg_data_i;
  logic [VSTART_W-1:0]  vstart_i;
  rvv_xrm_e             vxrm_i;
  reg_wb_t [N-1:0]      reg_wb_o;
  logic                 cmd_pop_i;
  logic                 cmd_valid_o;
  rvv_cmd_t             cmd_o;
  logic [4:0]           free_slots_o;
  logic                 config_valid_o;
  rvv_config_t          config_o;

  row_t        rows [NROWS];
  string       names [NROWS];
  int          nrows;
  row_t        cur;
  string       build_name;
  string       test_name;
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  // Reference model state
  rvv_config_t model_cfg;
  rvv_cmd_t    exp_q [$];

  rvv_frontend_top #(
    .N           (N),
    .QUEUE_DEPTH (DEPTH)
  ) uut (
    .clk            (clk),
    .rstn           (rstn),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .inst_ready_o   (inst_ready_o),
    .reg_data_i     (reg_data_i),
    .vstart_i       (vstart_i),
    .vxrm_i         (vxrm_i),
    .reg_wb_o       (reg_wb_o),
    .cmd_pop_i      (cmd_pop_i),
    .cmd_valid_o    (cmd_valid_o),
    .cmd_o          (cmd_o),
    .free_slots_o   (free_slots_o),
    .config_valid_o (config_valid_o),
    .config_o       (config_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Table length plus reset and a margin of cycles
  initial begin
    #((NROWS + 12) * 40);
    $display("Watchdog expired before the stimulus table was finished");
    $display("TEST FAILED");
    $finish;
  end

  // Galois step, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  task check_equal(input string what, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task start_row(input string name, input logic pop, input logic [VSTART_W-1:0] vstart,
                 input rvv_xrm_e xrm, input logic [N-1:0] ready);
    cur = '0;
    for (int i = 0; i < 2 * N; i++) begin
      cur.regs[i] = take_bits(32);
    end
    cur.pop = pop;
    cur.vstart = vstart;
    cur.vxrm = xrm;
    cur.exp_ready = ready;
    build_name = name;
  endtask

  task end_row();
    rows[nrows] = cur;
    names[nrows] = build_name;
    nrows++;
  endtask

  // Random body with a chosen funct3
  task put_cmd(input int lane, input rvv_opcode_e op, input logic [2:0] f3);
    logic [31:0] r;
    r = take_bits(25);
    cur.valid[lane] = 1'b1;
    cur.inst[lane].opcode = op;
    cur.inst[lane].bits = r[24:0];
    cur.inst[lane].bits.arith.funct3 = f3;
  endtask

  // OP-V arithmetic in every lane of the mask, never OPCFG
  task put_group(input logic [N-1:0] mask);
    logic [31:0] r;
    for (int lane = 0; lane < N; lane++) begin
      if (mask[lane]) begin
        r = take_bits(3);
        put_cmd(lane, RVV, (r[2:0] == 3'b111) ? 3'b110 : r[2:0]);
      end
    end
  endtask

  // sel 2'b0x vsetvli, 2'b11 vsetivli, 2'b10 vsetvl with vtype in rs2
  task put_vset(input int lane, input logic [1:0] sel, input logic [4:0] rd,
                input logic [31:0] avl, input rvv_lmul_e lmul, input rvv_sew_e sew,
                input logic ta, input logic ma);
    rvv_vset_fields_t v;
    put_cmd(lane, RVV, 3'b111);
    v = cur.inst[lane].bits.vset;
    v.sel = sel;
    v.rd = rd;
    if (sel == 2'b10) begin
      cur.regs[2*lane+1][7:0] = {ma, ta, sew, lmul};
    end else begin
      v.lmul = lmul;
      v.sew = sew;
      v.ta = ta;
      v.ma = ma;
    end
    if (sel == 2'b11) begin
      v.rs1_uimm = avl[4:0];
    end else begin
      cur.regs[2*lane] = avl;
    end
    cur.inst[lane].bits.vset = v;
    // New vl goes to rd one cycle after acceptance
    cur.exp_wb[lane] = 1'b1;
    cur.wb_addr[lane] = rd;
    cur.wb_data[lane] = avl;
  endtask

  task build_table();
    start_row("reset", 1'b0, '0, RNU, 4'b0000);
    end_row();
    // vset ahead of commands in the same group
    start_row("vset_chain", 1'b0, '0, RNU, 4'b1111);
    put_vset(0, 2'b00, 5'd5, 32'd7, LMUL2, SEW16, 1'b1, 1'b0);
    put_cmd(1, RVV, 3'b100);
    put_vset(2, 2'b11, 5'd6, 32'd3, LMUL1, SEW32, 1'b0, 1'b1);
    put_cmd(3, RVV, 3'b000);
    end_row();
    // Load with funct3 all ones is still a command
    start_row("vsetvl_mix", 1'b0, 7'd5, RDN, 4'b1111);
    put_cmd(0, RVV, 3'b011);
    put_vset(1, 2'b10, 5'd9, 32'd100, LMUL4, SEW8, 1'b1, 1'b1);
    put_cmd(2, LOAD, 3'b111);
    put_cmd(3, RVV, 3'b110);
    end_row();
    start_row("gap_lanes_1_3", 1'b0, '0, RNU, 4'b1010);
    put_group(4'b1010);
    end_row();
    start_row("gap_lanes_0_2", 1'b1, '0, RNU, 4'b0101);
    put_group(4'b0101);
    end_row();
    start_row("fill_a", 1'b0, 7'd3, ROD, 4'b1111);
    put_group(4'b1111);
    end_row();
    start_row("fill_b", 1'b0, '0, RNU, 4'b1111);
    put_group(4'b1111);
    end_row();
    // Free slots all taken by queued and staged commands
    start_row("capacity_zero", 1'b0, '0, RNU, 4'b0000);
    put_group(4'b1111);
    end_row();
    start_row("queue_full", 1'b0, '0, RNU, 4'b0000);
    put_group(4'b1111);
    end_row();
    start_row("full_with_pop", 1'b1, '0, RNU, 4'b0000);
    put_group(4'b1111);
    end_row();
    start_row("one_slot", 1'b1, '0, RNU, 4'b0010);
    put_group(4'b0110);
    end_row();
    start_row("staged_counted", 1'b1, '0, RNU, 4'b0001);
    put_group(4'b1101);
    end_row();
    // Drain, the last rows pop an empty queue
    for (int i = 0; i < 19; i++) begin
      start_row("drain", 1'b1, '0, RNU, 4'b0000);
      end_row();
    end
  endtask

  // vtype and vl rules of the three vset forms
  function automatic rvv_config_t apply_vset(input rvv_config_t cfg, input rvv_vset_fields_t v,
                                             input logic [31:0] rs1, input logic [31:0] rs2);
    rvv_config_t c;
    c = cfg;
    if (v.sel == 2'b10) begin
      c.vl = rs1;
      c.lmul = rvv_lmul_e'(rs2[2:0]);
      c.sew = rvv_sew_e'(rs2[5:3]);
      c.ta = rs2[6];
      c.ma = rs2[7];
    end else begin
      c.vl = (v.sel == 2'b11) ? 32'(v.rs1_uimm) : rs1;
      c.lmul = v.lmul;
      c.sew = v.sew;
      c.ta = v.ta;
      c.ma = v.ma;
    end
    return c;
  endfunction

  // Group accepted in row p, operands and CSRs of cycle c
  task process_group(input int p, input int c);
    rvv_config_t  cfg;
    rvv_cmd_t     cmd;
    rvv_inst_t    inst;
    logic [N-1:0] acc;
    acc = rows[p].valid & rows[p].exp_ready;
    cfg = model_cfg;
    cfg.vstart = rows[c].vstart;
    cfg.xrm = rows[c].vxrm;
    for (int lane = 0; lane < N; lane++) begin
      if (acc[lane]) begin
        inst = rows[p].inst[lane];
        if (inst.opcode == RVV && inst.bits.vset.funct3 == 3'b111) begin
          cfg = apply_vset(cfg, inst.bits.vset, rows[p].regs[2*lane], rows[p].regs[2*lane+1]);
        end else begin
          cmd.opcode = inst.opcode;
          cmd.bits = inst.bits;
          cmd.arch_state = cfg;
          cmd.rs1 = inst.bits.arith.funct3[2] ? rows[p].regs[2*lane] : 32'h0;
          exp_q.push_back(cmd);
        end
      end
    end
    if (acc != '0) begin
      model_cfg = cfg;
    end
  endtask

  // Mid-cycle checks, then the model steps like the next edge
  task check_cycle(input int c);
    logic [N-1:0] prev_acc;
    logic [N-1:0] exp_wb;
    prev_acc = '0;
    exp_wb = '0;
    if (c > 0) begin
      prev_acc = rows[c-1].valid & rows[c-1].exp_ready;
      exp_wb = rows[c-1].exp_wb;
    end
    check_equal("ready", 128'(rows[c].exp_ready), 128'(inst_ready_o));
    check_equal("free_slots", 128'(DEPTH - exp_q.size()), 128'(free_slots_o));
    check_equal("cmd_valid", 128'(exp_q.size() != 0), 128'(cmd_valid_o));
    check_equal("config_valid", 128'(prev_acc == '0), 128'(config_valid_o));
    if (prev_acc == '0) begin
      check_equal("config", 128'(model_cfg), 128'(config_o));
    end
    for (int lane = 0; lane < N; lane++) begin
      check_equal($sformatf("wb%0d valid", lane), 128'(exp_wb[lane]), 128'(reg_wb_o[lane].valid));
      if (exp_wb[lane]) begin
        check_equal($sformatf("wb%0d addr", lane), 128'(rows[c-1].wb_addr[lane]),
                    128'(reg_wb_o[lane].addr));
        check_equal($sformatf("wb%0d data", lane), 128'(rows[c-1].wb_data[lane]),
                    128'(reg_wb_o[lane].data));
      end
    end
    if (rows[c].pop && exp_q.size() != 0) begin
      check_equal("popped command", 128'(exp_q[0]), 128'(cmd_o));
      void'(exp_q.pop_front());
    end
    if (c > 0) begin
      process_group(c - 1, c);
    end
  endtask

  initial begin
    rstn = 1'b0;
    inst_valid_i = '0;
    inst_i = '0;
    reg_data_i = '0;
    vstart_i = '0;
    vxrm_i = RNU;
    cmd_pop_i = 1'b0;
    lfsr = 32'had7e4e27;
    errors = 0;
    checks = 0;
    nrows = 0;
    test_name = "reset";
    model_cfg = '{vl: 32'd16, vstart: '0, xrm: RNU, lmul: LMUL1, sew: SEW8, ta: 1'b0, ma: 1'b0};
    build_table();
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      @(posedge clk);
      inst_valid_i <= rows[r].valid;
      inst_i <= rows[r].inst;
      cmd_pop_i <= rows[r].pop;
      vstart_i <= rows[r].vstart;
      vxrm_i <= rows[r].vxrm;
      reg_data_i <= (r > 0) ? rows[r-1].regs : '0;
      @(negedge clk);
      test_name = names[r];
      check_cycle(r);
    end
    @(posedge clk);
    inst_valid_i <= '0;
    cmd_pop_i <= 1'b0;
    @(negedge clk);
    // Every accepted command must have left the queue
    assert (exp_q.size() == 0 && !cmd_valid_o) else begin
      errors++;
      $display("Queue not drained at the end, %0d commands still expected", exp_q.size());
    end
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/rvv_isa_pkg.sv
source/rvv_cmd_pkg.sv
source/cmd_aligner.sv
source/cmd_queue.sv
source/rvv_front_end.sv
source/rvv_frontend_top.sv
bench/rvv_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
verilator --binary --assert --top-module rvv_frontend_tb -f flist.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log
